//--- sources.f
verilog/dmem_pkg.sv
verilog/dmem_window_regs.sv
verilog/dmem_req_queue.sv
verilog/data_ram.sv
verilog/dmem_issue.sv
verilog/dmem_top.sv
testbench/dmem_properties.sv
testbench/dmem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module dmem_tb -o dmem_sim \
   && ./obj_dir/dmem_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Everything OK" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- testbench/dmem_tb.sv
// Testbench for dmem_top with random credit-based traffic, reference memory model, checks and watchdog
module dmem_tb;

   localparam int REQ_DEPTH      = 4;
   localparam int RSP_CREDITS    = 2;
   localparam int MEM_WORDS      = 256;
   localparam int IDX_W          = $clog2(MEM_WORDS);
   localparam int SEED           = 55429;
   localparam int N_RAND         = 300;                      // Base window traffic
   localparam int N_HOLD         = REQ_DEPTH + RSP_CREDITS;  // Fills queue plus credits
   localparam int N_RELOC        = 150;                      // After window move
   localparam int N_SHRINK       = 100;                      // Limit below RAM end
   localparam int TOTAL_REQS     = MEM_WORDS + N_RAND + N_HOLD + N_RELOC + N_SHRINK;
   localparam int TIMEOUT_CYCLES = TOTAL_REQS * 20;
   localparam dmem_pkg::addr_t RAM_BYTES = dmem_pkg::addr_t'(MEM_WORDS * 4);

   logic            clk = 1'b0;
   logic            i_arst_n;
   logic            i_req_valid;
   logic            i_req_wr;
   dmem_pkg::addr_t i_req_addr;
   dmem_pkg::strb_t i_req_strb;
   dmem_pkg::data_t i_req_wdata;
   logic            i_rsp_credit;
   logic            i_cfg_wr;
   logic            i_cfg_sel;
   dmem_pkg::addr_t i_cfg_wdata;
   logic            o_req_credit;
   logic            o_rsp_valid;
   logic            o_rsp_err;
   dmem_pkg::data_t o_rsp_data;
   dmem_pkg::cnt_t  o_fault_count;

   integer          seed = SEED;           // Requester stream
   integer          cred_seed = SEED + 1;  // Consumer stream
   logic [31:0]     cred_rnd;

   logic [3:0][7:0] mem_model [MEM_WORDS];  // Bytes per word
   dmem_pkg::addr_t model_base  = '0;
   dmem_pkg::addr_t model_limit = RAM_BYTES - 32'd1;
   int              model_faults = 0;
   logic            exp_err_q [$];
   dmem_pkg::data_t exp_data_q [$];

   int   sent_count = 0;        // Requests driven
   int   credit_pulses = 0;     // o_req_credit pulses seen
   int   rsp_seen = 0;
   int   credits_returned = 0;  // i_rsp_credit pulses driven
   logic hold_credits = 1'b0;   // Consumer withholds credits
   int   mon_errors = 0;
   int   seq_errors = 0;

   dmem_top #(
      .REQ_DEPTH(REQ_DEPTH), .RSP_CREDITS(RSP_CREDITS), .MEM_WORDS(MEM_WORDS)
   ) i_dut (
      .clk, .i_arst_n,
      .i_req_valid, .i_req_wr, .i_req_addr, .i_req_strb, .i_req_wdata,
      .i_rsp_credit,
      .i_cfg_wr, .i_cfg_sel, .i_cfg_wdata,
      .o_req_credit, .o_rsp_valid, .o_rsp_err, .o_rsp_data, .o_fault_count
   );

   always #50 clk = ~clk;

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp,
                        inout int count);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         count++;
      end
   endtask

   function automatic int credits_held();
      return REQ_DEPTH - sent_count + credit_pulses;
   endfunction

   // Fault rule and byte merge applied in request order
   task automatic model_request(input logic wr, input dmem_pkg::addr_t addr,
                                input dmem_pkg::strb_t strb, input dmem_pkg::data_t wdata);
      dmem_pkg::addr_t  off;
      logic [IDX_W-1:0] w;
      logic [31:0]      mask;
      logic             bad;
      off  = addr - model_base;
      bad  = (addr[1:0] != 2'b00) || (addr < model_base) || (addr > model_limit)
             || (off >= RAM_BYTES);
      w    = off[IDX_W+1:2];
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      if (bad) begin
         exp_err_q.push_back(1'b1);
         exp_data_q.push_back(dmem_pkg::FAULT_DATA);
         model_faults++;
      end else if (wr) begin
         mem_model[w] = (mem_model[w] & ~mask) | (wdata & mask);  // Lanes under strobe
         exp_err_q.push_back(1'b0);
         exp_data_q.push_back('0);  // Stores answer zero
      end else begin
         exp_err_q.push_back(1'b0);
         exp_data_q.push_back(mem_model[w]);
      end
   endtask

   task automatic send_req(input logic wr, input dmem_pkg::addr_t addr,
                           input dmem_pkg::strb_t strb, input dmem_pkg::data_t wdata);
      logic [31:0] gap;
      gap = $random(seed);
      @(posedge clk);
      if (gap[2:0] == 3'd0) begin
         i_req_valid <= 1'b0;  // Random idle cycle
         @(posedge clk);
      end
      while (credits_held() == 0) begin
         i_req_valid <= 1'b0;  // Out of credits
         @(posedge clk);
      end
      i_req_valid <= 1'b1;
      i_req_wr    <= wr;
      i_req_addr  <= addr;
      i_req_strb  <= strb;
      i_req_wdata <= wdata;
      model_request(wr, addr, strb, wdata);
      sent_count++;
   endtask

   // Mostly good word addresses, some misaligned or off the window
   task automatic random_traffic(input int n);
      logic [31:0]     rnd;
      dmem_pkg::addr_t addr;
      dmem_pkg::data_t wdata;
      for (int i = 0; i < n; i++) begin
         rnd   = $random(seed);
         wdata = $random(seed);
         addr  = model_base + {22'd0, rnd[13:6], 2'b00};
         if (rnd[17:15] == 3'd0) begin
            addr[1:0] = (rnd[5:4] == 2'b00) ? 2'b10 : rnd[5:4];  // Misaligned by 1 to 3
         end else if (rnd[17:15] == 3'd1) begin
            addr = addr + 32'h400;         // Past limit or past RAM
         end else if (rnd[17:15] == 3'd2 && model_base != '0) begin
            addr = model_base - 32'd4;     // Below base
         end
         send_req(rnd[18], addr, rnd[22:19], wdata);
      end
   endtask

   task automatic drain();
      @(posedge clk);
      i_req_valid <= 1'b0;
      while (rsp_seen != sent_count) begin
         @(posedge clk);
      end
      @(negedge clk);
   endtask

   task automatic cfg_write(input logic sel, input dmem_pkg::addr_t value);
      @(posedge clk);
      i_cfg_wr    <= 1'b1;
      i_cfg_sel   <= sel;
      i_cfg_wdata <= value;
      @(posedge clk);
      i_cfg_wr    <= 1'b0;
      if (sel) begin
         model_limit = value;
      end else begin
         model_base = value;
      end
   endtask

   // Consumer returns credits after random delays
   always @(posedge clk) begin
      cred_rnd = $random(cred_seed);
      if (i_arst_n && !hold_credits && (rsp_seen > credits_returned) && cred_rnd[1:0] != 2'd0) begin
         i_rsp_credit <= 1'b1;
         credits_returned++;
      end else begin
         i_rsp_credit <= 1'b0;
      end
   end

   // Outputs sampled mid-cycle
   always @(negedge clk) begin
      if (i_arst_n) begin
         if (o_req_credit) begin
            credit_pulses++;
         end
         check("requester credits in range",
               {31'd0, credits_held() >= 0 && credits_held() <= REQ_DEPTH}, 32'd1, mon_errors);
         if (o_rsp_valid) begin
            if (exp_data_q.size() == 0) begin
               $display("Response arrived with no request outstanding");
               mon_errors++;
            end else begin
               check("o_rsp_err", {31'd0, o_rsp_err}, {31'd0, exp_err_q.pop_front()}, mon_errors);
               check("o_rsp_data", o_rsp_data, exp_data_q.pop_front(), mon_errors);
            end
            rsp_seen++;
            check("responses without credit back",
                  {31'd0, (rsp_seen - credits_returned) <= RSP_CREDITS}, 32'd1, mon_errors);
         end
      end
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles, traffic did not drain", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
   end

   initial begin
      int seen_before;
      i_arst_n     = 1'b0;
      i_req_valid  = 1'b0;
      i_req_wr     = 1'b0;
      i_req_addr   = '0;
      i_req_strb   = '0;
      i_req_wdata  = '0;
      i_rsp_credit = 1'b0;
      i_cfg_wr     = 1'b0;
      i_cfg_sel    = 1'b0;
      i_cfg_wdata  = '0;
      repeat (3) @(posedge clk);
      i_arst_n <= 1'b1;
      @(negedge clk);
      check("o_rsp_valid", {31'd0, o_rsp_valid}, 32'd0, seq_errors);
      check("o_req_credit", {31'd0, o_req_credit}, 32'd0, seq_errors);
      check("o_fault_count", {16'd0, o_fault_count}, 32'd0, seq_errors);
      for (int i = 0; i < MEM_WORDS; i++) begin
         send_req(1'b1, 32'(i * 4), 4'hF, $random(seed));  // Whole RAM defined
      end
      random_traffic(N_RAND);
      drain();
      check("o_fault_count", {16'd0, o_fault_count}, 32'(model_faults), seq_errors);
      while (credits_returned != rsp_seen) begin
         @(posedge clk);
      end
      hold_credits <= 1'b1;
      seen_before = rsp_seen;
      random_traffic(N_HOLD);
      @(posedge clk);
      i_req_valid <= 1'b0;
      repeat (20) @(posedge clk);
      @(negedge clk);
      check("responses while credits held", 32'(rsp_seen - seen_before), 32'(RSP_CREDITS),
            seq_errors);
      hold_credits <= 1'b0;
      drain();
      cfg_write(1'b0, 32'h100);  // Word 0 now at 0x100
      cfg_write(1'b1, 32'h5FF);  // Window reaches past RAM end
      random_traffic(N_RELOC);
      drain();
      cfg_write(1'b1, 32'h2FF);  // Limit now inside RAM
      random_traffic(N_SHRINK);
      drain();
      check("o_fault_count", {16'd0, o_fault_count}, 32'(model_faults), seq_errors);
      check("o_req_credit pulses", 32'(credit_pulses), 32'(sent_count), seq_errors);
      $display("Errors: %0d in responses, %0d in sequence checks, %0d responses seen",
               mon_errors, seq_errors, rsp_seen);
      if (mon_errors == 0 && seq_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- testbench/dmem_properties.sv
// Assertions on the issue stage: response credit bound, response after pop, no pop without credit
module dmem_properties #(
   parameter int RSP_CREDITS = 2        // Credits after reset
) (
   input logic           clk,
   input logic           i_arst_n,
   input logic           i_pop,          // Issue pops queue head
   input logic           i_rsp_valid,
   input dmem_pkg::cnt_t i_rsp_cred      // Credits in hand
);

   localparam dmem_pkg::cnt_t MAX_CRED = dmem_pkg::cnt_t'(RSP_CREDITS);

   // Consumer never returns more than it was given
   a_cred_max : assert property (@(posedge clk) disable iff (!i_arst_n)
      i_rsp_cred <= MAX_CRED)
      else $error("Response credit count %0d above %0d", i_rsp_cred, MAX_CRED);

   // Response is the registered pop
   a_rsp_after_pop : assert property (@(posedge clk) disable iff (!i_arst_n)
      i_rsp_valid |-> $past(i_pop))
      else $error("Response valid without a pop in the previous cycle");

   a_pop_has_cred : assert property (@(posedge clk) disable iff (!i_arst_n)
      i_pop |-> (i_rsp_cred != '0))
      else $error("Pop with no response credit left");

endmodule

bind dmem_issue dmem_properties #(.RSP_CREDITS(RSP_CREDITS)) u_props (
   .clk,
   .i_arst_n,
   .i_pop       (o_pop),
   .i_rsp_valid (o_rsp_valid),
   .i_rsp_cred  (rsp_cred_q)
);

//--- verilog/dmem_top.sv
// Data memory subsystem top: request queue, issue stage, byte-lane RAM and window registers
module dmem_top #(
   parameter int REQ_DEPTH   = 4,       // Queue depth and request credits
   parameter int RSP_CREDITS = 2,       // Initial response credits
   parameter int MEM_WORDS   = 256      // RAM size in words
) (
   input  logic               clk,
   input  logic               i_arst_n,
   input  logic               i_req_valid,
   input  logic               i_req_wr,
   input  dmem_pkg::addr_t    i_req_addr,
   input  dmem_pkg::strb_t    i_req_strb,
   input  dmem_pkg::data_t    i_req_wdata,
   input  logic               i_rsp_credit,
   input  logic               i_cfg_wr,
   input  logic               i_cfg_sel,
   input  dmem_pkg::addr_t    i_cfg_wdata,
   output logic               o_req_credit,
   output logic               o_rsp_valid,
   output logic               o_rsp_err,
   output dmem_pkg::data_t    o_rsp_data,
   output dmem_pkg::cnt_t     o_fault_count
);

   // Queue head
   logic            head_wr;
   dmem_pkg::addr_t head_addr;
   dmem_pkg::strb_t head_strb;
   dmem_pkg::data_t head_wdata;
   logic            not_empty;
   logic            pop;

   // RAM port
   logic                         ram_en;
   logic                         ram_wr;
   logic [$clog2(MEM_WORDS)-1:0] ram_index;
   dmem_pkg::strb_t              ram_strb;
   dmem_pkg::data_t              ram_wdata;
   dmem_pkg::data_t              ram_rdata;

   // Window and fault
   dmem_pkg::addr_t win_base;
   dmem_pkg::addr_t win_limit;
   logic            fault;

   dmem_req_queue #(.REQ_DEPTH(REQ_DEPTH)) u_queue (
      .clk, .i_arst_n,
      .i_req_valid, .i_req_wr, .i_req_addr, .i_req_strb, .i_req_wdata,
      .i_pop        (pop),
      .o_head_wr    (head_wr),
      .o_head_addr  (head_addr),
      .o_head_strb  (head_strb),
      .o_head_wdata (head_wdata),
      .o_not_empty  (not_empty),
      .o_req_credit                     // Pop leaves as request credit
   );

   dmem_issue #(.RSP_CREDITS(RSP_CREDITS), .MEM_WORDS(MEM_WORDS)) u_issue (
      .clk, .i_arst_n,
      .i_not_empty (not_empty),
      .i_head_wr   (head_wr),
      .i_head_addr (head_addr),
      .i_head_strb (head_strb),
      .i_head_wdata(head_wdata),
      .i_win_base  (win_base),
      .i_win_limit (win_limit),
      .i_ram_rdata (ram_rdata),
      .i_rsp_credit,
      .o_pop       (pop),
      .o_ram_en    (ram_en),
      .o_ram_wr    (ram_wr),
      .o_ram_index (ram_index),
      .o_ram_strb  (ram_strb),
      .o_ram_wdata (ram_wdata),
      .o_fault     (fault),
      .o_rsp_valid, .o_rsp_err, .o_rsp_data
   );

   data_ram #(.MEM_WORDS(MEM_WORDS)) u_ram (
      .clk,
      .i_en    (ram_en),
      .i_wr_en (ram_wr),
      .i_index (ram_index),
      .i_strb  (ram_strb),
      .i_wdata (ram_wdata),
      .o_rdata (ram_rdata)
   );

   dmem_window_regs #(.MEM_WORDS(MEM_WORDS)) u_window (
      .clk, .i_arst_n,
      .i_cfg_wr, .i_cfg_sel, .i_cfg_wdata,
      .i_fault      (fault),
      .o_win_base   (win_base),
      .o_win_limit  (win_limit),
      .o_fault_count
   );

endmodule

//--- verilog/dmem_issue.sv
// Issue stage: response credit count, window and alignment check, RAM drive and response forming
module dmem_issue #(
   parameter int RSP_CREDITS = 2,       // Credits held after reset
   parameter int MEM_WORDS   = 256      // RAM size in words
) (
   input  logic                         clk,
   input  logic                         i_arst_n,
   input  logic                         i_not_empty,   // Queue has a head
   input  logic                         i_head_wr,
   input  dmem_pkg::addr_t              i_head_addr,
   input  dmem_pkg::strb_t              i_head_strb,
   input  dmem_pkg::data_t              i_head_wdata,
   input  dmem_pkg::addr_t              i_win_base,
   input  dmem_pkg::addr_t              i_win_limit,
   input  dmem_pkg::data_t              i_ram_rdata,   // Registered RAM word
   input  logic                         i_rsp_credit,  // Consumer returns one
   output logic                         o_pop,
   output logic                         o_ram_en,
   output logic                         o_ram_wr,
   output logic [$clog2(MEM_WORDS)-1:0] o_ram_index,
   output dmem_pkg::strb_t              o_ram_strb,
   output dmem_pkg::data_t              o_ram_wdata,
   output logic                         o_fault,       // To fault counter
   output logic                         o_rsp_valid,
   output logic                         o_rsp_err,
   output dmem_pkg::data_t              o_rsp_data
);

   localparam int IDX_W = $clog2(MEM_WORDS);
   localparam dmem_pkg::addr_t RAM_BYTES = dmem_pkg::addr_t'(MEM_WORDS * 4);

   dmem_pkg::cnt_t  rsp_cred_q;         // Response credits in hand
   dmem_pkg::addr_t offset;             // Byte offset into window
   logic            aligned;
   logic            in_window;
   logic            in_ram;
   logic            fault;              // Head access is illegal

   logic            rsp_valid_q;        // Pop happened last cycle
   logic            rsp_err_q;          // It faulted
   logic            rsp_wr_q;           // It was a store

   // Pop only with a head and a credit to spend on its response
   assign o_pop = i_not_empty && (rsp_cred_q != '0);

   // Spend on pop, refund on consumer credit, both may land together
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rsp_cred_q <= dmem_pkg::cnt_t'(RSP_CREDITS);
      end else begin
         case ({o_pop, i_rsp_credit})
            2'b10:   rsp_cred_q <= rsp_cred_q - 1'b1;
            2'b01:   rsp_cred_q <= rsp_cred_q + 1'b1;
            default: rsp_cred_q <= rsp_cred_q;
         endcase
      end
   end

   // Address check against current window
   assign offset    = i_head_addr - i_win_base;
   assign aligned   = (i_head_addr[1:0] == 2'b00);
   assign in_window = (i_head_addr >= i_win_base) && (i_head_addr <= i_win_limit);
   assign in_ram    = (offset < RAM_BYTES);          // Window may reach past RAM
   assign fault     = !(aligned && in_window && in_ram);

   // RAM sees only good accesses
   assign o_ram_en    = o_pop && !fault;
   assign o_ram_wr    = o_ram_en && i_head_wr;
   assign o_ram_index = offset[IDX_W+1:2];           // Offset over four
   assign o_ram_strb  = i_head_strb;
   assign o_ram_wdata = i_head_wdata;

   assign o_fault = o_pop && fault;     // Counted one cycle later

   // Response side state, lines up with the RAM read latency
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rsp_valid_q <= 1'b0;
         rsp_err_q   <= 1'b0;
         rsp_wr_q    <= 1'b0;
      end else begin
         rsp_valid_q <= o_pop;
         if (o_pop) begin
            rsp_err_q <= fault;
            rsp_wr_q  <= i_head_wr;
         end
      end
   end

   assign o_rsp_valid = rsp_valid_q;
   assign o_rsp_err   = rsp_err_q;

   // Fault data wins, stores answer with zero, loads with the RAM word
   always_comb begin
      if (rsp_err_q) begin
         o_rsp_data = dmem_pkg::FAULT_DATA;
      end else if (rsp_wr_q) begin
         o_rsp_data = '0;
      end else begin
         o_rsp_data = i_ram_rdata;
      end
   end

endmodule

//--- verilog/data_ram.sv
// Word-organized byte-lane RAM with byte-enabled writes and registered read of the old word
module data_ram #(
   parameter int MEM_WORDS = 256        // Depth in words
) (
   input  logic                         clk,
   input  logic                         i_en,      // Access this cycle
   input  logic                         i_wr_en,   // Store when enabled
   input  logic [$clog2(MEM_WORDS)-1:0] i_index,   // Word index
   input  dmem_pkg::strb_t              i_strb,    // Lanes to write
   input  dmem_pkg::data_t              i_wdata,
   output dmem_pkg::data_t              o_rdata    // Valid cycle after i_en
);

   localparam int LANES  = $bits(dmem_pkg::strb_t);
   localparam int LANE_W = $bits(dmem_pkg::data_t) / LANES;  // 8 bits

   // One narrow array per byte lane, strobe picks which lanes take the write
   for (genvar l = 0; l < LANES; l++) begin : g_lane
      logic [LANE_W-1:0] mem [MEM_WORDS];  // Contents undefined until written
      logic [LANE_W-1:0] rd_q;             // Registered lane read

      always_ff @(posedge clk) begin
         if (i_en) begin
            rd_q <= mem[i_index];          // Old value, read before write
            if (i_wr_en && i_strb[l]) begin
               mem[i_index] <= i_wdata[l*LANE_W +: LANE_W];
            end
         end
      end

      assign o_rdata[l*LANE_W +: LANE_W] = rd_q;  // Lanes packed back into word
   end

endmodule

//--- verilog/dmem_req_queue.sv
// Circular request FIFO with head read-out and request credit return on pop
module dmem_req_queue #(
   parameter int REQ_DEPTH = 4          // Entries, equals requester credits
) (
   input  logic               clk,
   input  logic               i_arst_n,
   input  logic               i_req_valid,   // Push, backed by a credit
   input  logic               i_req_wr,      // 1 store, 0 load
   input  dmem_pkg::addr_t    i_req_addr,
   input  dmem_pkg::strb_t    i_req_strb,
   input  dmem_pkg::data_t    i_req_wdata,
   input  logic               i_pop,         // From issue stage
   output logic               o_head_wr,
   output dmem_pkg::addr_t    o_head_addr,
   output dmem_pkg::strb_t    o_head_strb,
   output dmem_pkg::data_t    o_head_wdata,
   output logic               o_not_empty,
   output logic               o_req_credit   // One pulse per popped entry
);

   localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
   localparam int CNT_W = $clog2(REQ_DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(REQ_DEPTH - 1);

   // Entry storage, payload only so no reset
   logic            wr_q    [REQ_DEPTH];
   dmem_pkg::addr_t addr_q  [REQ_DEPTH];
   dmem_pkg::strb_t strb_q  [REQ_DEPTH];
   dmem_pkg::data_t wdata_q [REQ_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;          // Next free slot
   logic [PTR_W-1:0] rd_ptr_q;          // Current head
   logic [CNT_W-1:0] count_q;           // Occupancy
   logic             do_pop;            // Pop of a real entry

   assign do_pop = i_pop && o_not_empty;

   // No full check, the credit rule keeps a slot free for every push
   always_ff @(posedge clk) begin
      if (i_req_valid) begin
         wr_q[wr_ptr_q]    <= i_req_wr;
         addr_q[wr_ptr_q]  <= i_req_addr;
         strb_q[wr_ptr_q]  <= i_req_strb;
         wdata_q[wr_ptr_q] <= i_req_wdata;
      end
   end

   // Pointers wrap at REQ_DEPTH, which need not be a power of two
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (i_req_valid) begin
            wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({i_req_valid, do_pop})
            2'b10:   count_q <= count_q + 1'b1;  // Push only
            2'b01:   count_q <= count_q - 1'b1;  // Pop only
            default: count_q <= count_q;         // Both or neither
         endcase
      end
   end

   // Head seen by issue, a push lands here one cycle later at the earliest
   assign o_head_wr    = wr_q[rd_ptr_q];
   assign o_head_addr  = addr_q[rd_ptr_q];
   assign o_head_strb  = strb_q[rd_ptr_q];
   assign o_head_wdata = wdata_q[rd_ptr_q];

   assign o_not_empty  = (count_q != '0);
   assign o_req_credit = do_pop;        // Slot freed, same cycle as pop

endmodule

//--- verilog/dmem_window_regs.sv
// Window base and limit configuration registers with saturating access fault counter
module dmem_window_regs #(
   parameter int MEM_WORDS = 256        // RAM size in words, sets reset limit
) (
   input  logic               clk,
   input  logic               i_arst_n,
   input  logic               i_cfg_wr,      // Config write strobe
   input  logic               i_cfg_sel,     // 0 base, 1 limit
   input  dmem_pkg::addr_t    i_cfg_wdata,   // New base or limit
   input  logic               i_fault,       // Fault pulse from issue
   output dmem_pkg::addr_t    o_win_base,
   output dmem_pkg::addr_t    o_win_limit,
   output dmem_pkg::cnt_t     o_fault_count
);

   // Last byte address of the RAM, window covers all of it after reset
   localparam dmem_pkg::addr_t RAM_LAST_BYTE = dmem_pkg::addr_t'(MEM_WORDS * 4 - 1);

   localparam logic SEL_BASE  = 1'b0;
   localparam logic SEL_LIMIT = 1'b1;

   dmem_pkg::addr_t win_base_q;         // Lowest legal byte address
   dmem_pkg::addr_t win_limit_q;        // Highest legal byte address
   dmem_pkg::cnt_t  fault_cnt_q;        // Faults seen since reset
   logic            fault_cnt_full;     // Counter at its maximum

   // Window registers, written one at a time
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         win_base_q  <= '0;             // Start of RAM
         win_limit_q <= RAM_LAST_BYTE;  // End of RAM
      end else if (i_cfg_wr) begin
         if (i_cfg_sel == SEL_BASE) begin
            win_base_q <= i_cfg_wdata;
         end
         if (i_cfg_sel == SEL_LIMIT) begin
            win_limit_q <= i_cfg_wdata;
         end
      end
   end

   assign fault_cnt_full = &fault_cnt_q;  // All ones

   // Counter sticks at max rather than wrapping to zero
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         fault_cnt_q <= '0;
      end else if (i_fault && !fault_cnt_full) begin
         fault_cnt_q <= fault_cnt_q + 1'b1;  // One per faulting pop
      end
   end

   assign o_win_base    = win_base_q;
   assign o_win_limit   = win_limit_q;
   assign o_fault_count = fault_cnt_q;  // Read-back

endmodule

//--- verilog/dmem_pkg.sv
// Shared types and constants of the data memory subsystem: address, data, strobe, count, fault data
package dmem_pkg;

   // Byte address as seen by the requester
   typedef logic [31:0] addr_t;

   // One memory word, four byte lanes
   typedef logic [31:0] data_t;

   // Byte enables, bit n covers data bits 8n+7 down to 8n
   typedef logic [3:0] strb_t;

   // Fault and credit counts
   typedef logic [15:0] cnt_t;

   // Data returned with the error flag on any faulting access
   localparam data_t FAULT_DATA = 32'hDEAD_BEEF;

endpackage
